//--- lvda_pkg.sv
package lvda_pkg;

    // Telemetry word sizes.
    localparam int addr_width = 9;
    localparam int word_width = 26;
    localparam int half_width = 13;   // A half word carries the low data bits only.

    // The module code sits in the top address bits.
    localparam int code_width = 3;
    localparam logic [code_width-1:0] code_reject = 3'd0;

    // Address, full data word and the parity bit.
    localparam int max_frame = addr_width + word_width + 1;
    localparam int count_width = $clog2(max_frame + 1);

    localparam logic [count_width-1:0] full_len = count_width'(max_frame);
    localparam logic [count_width-1:0] half_len = count_width'(addr_width + half_width + 1);

    // External bit-time phases, each a level.
    typedef struct packed {
        logic wda;
        logic xda;
        logic yda;
        logic zda;
    } phase_t;

    // A request waiting for the serializer.
    typedef struct packed {
        logic                  valid;
        logic                  full;      // Address bit 8 selects the full word.
        logic [addr_width-1:0] address;
        logic [word_width-1:0] data;
    } tlm_request_t;

    typedef struct packed {
        logic bit_strobe;    // One cycle per bit time.
        logic phase_error;   // Sticky until reset.
    } bit_timing_t;

endpackage

//--- bit_timing.sv
`timescale 1ns/1ns
`default_nettype none

module bit_timing (
    input  logic                  sim_clk,
    input  logic                  reset,
    input  lvda_pkg::phase_t      phase,
    output lvda_pkg::bit_timing_t timing
);

    lvda_pkg::phase_t phase_q;   // Phase levels sampled at the last edge.
    lvda_pkg::phase_t phase_d;   // One edge older.

    logic [3:0] rise;
    logic [3:0] expected_hot;
    logic [1:0] expected;
    logic [1:0] next_expected;
    logic       locked;
    logic       order_bad;
    logic       bit_strobe_q;
    logic       phase_error_q;

    // Bit 3 is wda and bit 0 is zda, the order of phase_t.
    assign rise = phase_q & ~phase_d;
    assign expected_hot = 4'b1000 >> expected;

    // The first clean rise after reset sets the reference point.
    assign order_bad = locked && (rise != 4'b0000) && (rise != expected_hot);

    always_comb begin
        case (rise)
            4'b1000: next_expected = 2'd1;
            4'b0100: next_expected = 2'd2;
            4'b0010: next_expected = 2'd3;
            4'b0001: next_expected = 2'd0;
            default: next_expected = expected;
        endcase
    end

    always_ff @(posedge sim_clk) begin
        if (reset) begin
            phase_q <= '0;
            phase_d <= '0;
        end else begin
            phase_q <= phase;
            phase_d <= phase_q;
        end
    end

    always_ff @(posedge sim_clk) begin
        if (reset) begin
            expected      <= 2'd0;
            locked        <= 1'b0;
            bit_strobe_q  <= 1'b0;
            phase_error_q <= 1'b0;
        end else begin
            bit_strobe_q <= rise[3];   // Every wda rise starts a bit time.
            expected     <= next_expected;
            if ($onehot(rise)) begin
                locked <= 1'b1;
            end
            if (order_bad) begin
                phase_error_q <= 1'b1;
            end
        end
    end

    assign timing = '{bit_strobe: bit_strobe_q, phase_error: phase_error_q};

endmodule
`default_nettype wire

//--- address_decode.sv
`timescale 1ns/1ns
`default_nettype none

module address_decode (
    input  logic                             sim_clk,
    input  logic                             reset,
    input  logic                             pio,
    input  logic [lvda_pkg::addr_width-1:0]  address,
    input  logic [lvda_pkg::word_width-1:0]  data_word,
    input  logic                             taken,
    output lvda_pkg::tlm_request_t           request,
    output logic                             rejected,
    output logic                             overrun
);

    // Input stage, loaded while pio is high.
    logic                            pio_q;
    logic [lvda_pkg::addr_width-1:0] address_q;
    logic [lvda_pkg::word_width-1:0] data_word_q;

    // The single pending request.
    logic                            valid_q;
    logic                            full_q;
    logic [lvda_pkg::addr_width-1:0] pend_address;
    logic [lvda_pkg::word_width-1:0] pend_data;

    logic                            rejected_q;
    logic                            overrun_q;
    logic [lvda_pkg::code_width-1:0] code;
    logic                            code_ok;
    logic                            pending;
    logic                            accept;

    assign code = address_q[lvda_pkg::addr_width-1 -: lvda_pkg::code_width];
    assign code_ok = (code != lvda_pkg::code_reject);

    // A request taken in this cycle frees the slot at the same edge.
    assign pending = valid_q && !taken;
    assign accept = pio_q && code_ok && !pending;

    always_ff @(posedge sim_clk) begin
        if (reset) begin
            pio_q <= 1'b0;
        end else begin
            pio_q <= pio;
        end
    end

    always_ff @(posedge sim_clk) begin
        if (pio) begin
            address_q   <= address;
            data_word_q <= data_word;
        end
        if (accept) begin
            full_q       <= address_q[lvda_pkg::addr_width-1];
            pend_address <= address_q;
            pend_data    <= data_word_q;
        end
    end

    always_ff @(posedge sim_clk) begin
        if (reset) begin
            valid_q    <= 1'b0;
            rejected_q <= 1'b0;
            overrun_q  <= 1'b0;
        end else begin
            // A rejected request never needs the slot, so it cannot overrun.
            rejected_q <= pio_q && !code_ok;
            overrun_q  <= pio_q && code_ok && pending;
            if (accept) begin
                valid_q <= 1'b1;
            end else if (taken) begin
                valid_q <= 1'b0;
            end
        end
    end

    assign request = '{
        valid:   valid_q,
        full:    full_q,
        address: pend_address,
        data:    pend_data
    };

    assign rejected = rejected_q;
    assign overrun  = overrun_q;

endmodule
`default_nettype wire

//--- serial_sampler.sv
`timescale 1ns/1ns
`default_nettype none

module serial_sampler (
    input  logic                  sim_clk,
    input  logic                  reset,
    input  lvda_pkg::bit_timing_t timing,
    input  lvda_pkg::tlm_request_t request,
    output logic                  taken,
    output logic                  data,
    output logic                  data_gate
);

    logic [lvda_pkg::max_frame-1:0]   frame;
    logic [lvda_pkg::count_width-1:0] frame_len;
    logic [lvda_pkg::half_width-1:0]  half_data;
    logic                             parity;

    logic [lvda_pkg::max_frame-1:0]   shift_q;   // Bits still to send, MSB next.
    logic [lvda_pkg::count_width-1:0] count_q;   // Bits left, counting the one on data.
    logic                             data_q;
    logic                             gate_q;
    logic                             idle;
    logic                             load;

    assign half_data = request.data[lvda_pkg::half_width-1:0];

    // Odd parity over everything sent before it.
    always_comb begin
        if (request.full) begin
            parity = ~^{request.address, request.data};
            frame = {request.address, request.data, parity};
            frame_len = lvda_pkg::full_len;
        end else begin
            parity = ~^{request.address, half_data};
            frame = {request.address, half_data, parity,
                     {(lvda_pkg::word_width - lvda_pkg::half_width){1'b0}}};
            frame_len = lvda_pkg::half_len;
        end
    end

    // Free when no frame runs or its last bit is already on data.
    assign idle = (count_q[lvda_pkg::count_width-1:1] == '0);
    assign load = timing.bit_strobe && idle && request.valid;
    assign taken = load;

    always_ff @(posedge sim_clk) begin
        if (reset) begin
            count_q <= '0;
            data_q  <= 1'b0;
            gate_q  <= 1'b0;
        end else if (timing.bit_strobe) begin
            if (load) begin
                count_q <= frame_len;
                data_q  <= frame[lvda_pkg::max_frame-1];
                gate_q  <= 1'b1;
            end else if (idle) begin
                count_q <= '0;
                data_q  <= 1'b0;
                gate_q  <= 1'b0;
            end else begin
                count_q <= count_q - 1'b1;
                data_q  <= shift_q[lvda_pkg::max_frame-1];
            end
        end
    end

    always_ff @(posedge sim_clk) begin
        if (timing.bit_strobe) begin
            if (load) begin
                shift_q <= frame << 1;   // The MSB already went to data.
            end else begin
                shift_q <= shift_q << 1;
            end
        end
    end

    assign data = data_q;
    assign data_gate = gate_q;

endmodule
`default_nettype wire

//--- lvda.sv
`timescale 1ns/1ns
`default_nettype none

module lvda (
    input  logic                            sim_clk,
    input  logic                            reset,
    input  lvda_pkg::phase_t                phase,
    input  logic                            pio,
    input  logic [lvda_pkg::addr_width-1:0] address,
    input  logic [lvda_pkg::word_width-1:0] data_word,
    output logic                            data,
    output logic                            data_gate,
    output logic                            overrun,
    output logic                            rejected,
    output logic                            phase_error
);

    lvda_pkg::bit_timing_t  timing;
    lvda_pkg::tlm_request_t request;
    logic                   taken;

    bit_timing u_bit_timing (
        .sim_clk (sim_clk),
        .reset   (reset),
        .phase   (phase),
        .timing  (timing)
    );

    address_decode u_address_decode (
        .sim_clk   (sim_clk),
        .reset     (reset),
        .pio       (pio),
        .address   (address),
        .data_word (data_word),
        .taken     (taken),
        .request   (request),
        .rejected  (rejected),
        .overrun   (overrun)
    );

    serial_sampler u_serial_sampler (
        .sim_clk   (sim_clk),
        .reset     (reset),
        .timing    (timing),
        .request   (request),
        .taken     (taken),
        .data      (data),
        .data_gate (data_gate)
    );

    assign phase_error = timing.phase_error;

endmodule
`default_nettype wire

//--- lvda_props.sv
`timescale 1ns/1ns

module lvda_props (
    input logic sim_clk,
    input logic reset,
    input logic data_gate,
    input logic rejected,
    input logic overrun,
    input logic phase_error
);

    // The serial output is quiet right after reset.
    assert property (@(posedge sim_clk) reset |=> !data_gate)
        else $error("data_gate high in the cycle after reset");

    assert property (@(posedge sim_clk) !(rejected && overrun))
        else $error("rejected and overrun high together");

    assert property (@(posedge sim_clk) disable iff (reset) rejected |=> !rejected)
        else $error("rejected lasted more than one cycle");

    assert property (@(posedge sim_clk) disable iff (reset) overrun |=> !overrun)
        else $error("overrun lasted more than one cycle");

    // A phase error is sticky.
    assert property (@(posedge sim_clk) (phase_error && !reset) |=> (phase_error || reset))
        else $error("phase_error fell without a reset");

endmodule

bind lvda lvda_props u_props (
    .sim_clk     (sim_clk),
    .reset       (reset),
    .data_gate   (data_gate),
    .rejected    (rejected),
    .overrun     (overrun),
    .phase_error (phase_error)
);

//--- lvda_checker.sv
`timescale 1ns/1ns

module lvda_checker (
    input logic                            sim_clk,
    input logic                            reset,
    input lvda_pkg::phase_t                phase,
    input logic                            pio,
    input logic [lvda_pkg::addr_width-1:0] address,
    input logic [lvda_pkg::word_width-1:0] data_word,
    input logic                            data,
    input logic                            data_gate,
    input logic                            overrun,
    input logic                            rejected
);

    int errors = 0;
    int frames = 0;
    logic busy = 1'b0;

    logic [35:0] exp_q[$];         // Frames loaded into the serializer, oldest first.
    int          len_q[$];
    logic        model_pending = 1'b0;
    logic [35:0] pend_bits;
    int          pend_len;
    int          rem = 0;          // Bits left in the running frame.
    logic        in_frame = 1'b0;
    logic [35:0] cur_bits;
    logic [35:0] got_bits;
    int          cur_len;
    int          idx;
    logic        rej_p1 = 1'b0;
    logic        rej_p2 = 1'b0;
    logic        ovr_p1 = 1'b0;
    logic        ovr_p2 = 1'b0;
    logic        prev_wda = 1'b0;
    logic        prev_zda = 1'b0;

    // The expected frame is right aligned, with the first bit at position len-1.
    function automatic logic [35:0] ref_frame(input logic [8:0] a, input logic [25:0] d,
                                              output int len);
        logic [35:0] f;
        int          ones;
        int          nbits;
        f = '0;
        len = 0;
        ones = 0;
        nbits = a[8] ? 26 : 13;
        for (int i = 8; i >= 0; i--) begin
            f = {f[34:0], a[i]};
            ones += int'(a[i]);
            len++;
        end
        for (int i = nbits - 1; i >= 0; i--) begin
            f = {f[34:0], d[i]};
            ones += int'(d[i]);
            len++;
        end
        f = {f[34:0], ((ones % 2) == 0)};   // Parity makes the count odd.
        len++;
        return f;
    endfunction

    always @(posedge sim_clk) begin : step
        if (reset) begin
            exp_q.delete();
            len_q.delete();
            model_pending = 1'b0;
            rem = 0;
            in_frame = 1'b0;
            {rej_p1, rej_p2, ovr_p1, ovr_p2} = '0;
        end else begin
            if (rejected !== rej_p2) begin
                $display("ERROR t=%0t rejected expected %0b got %0b", $time, rej_p2, rejected);
                errors++;
            end
            if (overrun !== ovr_p2) begin
                $display("ERROR t=%0t overrun expected %0b got %0b", $time, ovr_p2, overrun);
                errors++;
            end
            rej_p2 = rej_p1;
            ovr_p2 = ovr_p1;
            rej_p1 = 1'b0;
            ovr_p1 = 1'b0;

            // One serializer step per bit time.
            if (phase.wda && !prev_wda) begin
                if (rem <= 1) begin
                    rem = 0;
                    if (model_pending) begin
                        exp_q.push_back(pend_bits);
                        len_q.push_back(pend_len);
                        rem = pend_len;
                        model_pending = 1'b0;
                    end
                end else begin
                    rem--;
                end
            end

            if (phase.zda && !prev_zda) begin
                if (data_gate) begin
                    if (!in_frame && exp_q.size() == 0) begin
                        $display("Frame bit on data at t=%0t with no frame expected", $time);
                        errors++;
                    end else if (!in_frame) begin
                        cur_bits = exp_q.pop_front();
                        cur_len = len_q.pop_front();
                        got_bits = '0;
                        idx = 0;
                        in_frame = 1'b1;
                    end
                    if (in_frame) begin
                        got_bits[cur_len-1-idx] = data;
                        idx++;
                        if (idx == cur_len) begin
                            if (got_bits !== cur_bits) begin
                                $display("ERROR t=%0t data expected %h got %h",
                                         $time, cur_bits, got_bits);
                                errors++;
                            end
                            frames++;
                            in_frame = 1'b0;
                        end
                    end
                end else if (in_frame) begin
                    $display("data_gate dropped at t=%0t after %0d of %0d bits",
                             $time, idx, cur_len);
                    errors++;
                    in_frame = 1'b0;
                end
            end

            if (pio) begin
                if (address[8:6] == lvda_pkg::code_reject) begin
                    rej_p1 = 1'b1;
                end else if (model_pending) begin
                    ovr_p1 = 1'b1;
                end else begin
                    pend_bits = ref_frame(address, data_word, pend_len);
                    model_pending = 1'b1;
                end
            end
        end
        prev_wda = phase.wda;
        prev_zda = phase.zda;
        busy = model_pending || (rem > 0) || (exp_q.size() > 0) || in_frame ||
               rej_p1 || rej_p2 || ovr_p1 || ovr_p2;
    end

endmodule

//--- tb_lvda.sv
`timescale 1ns/1ns

module tb_lvda;

    logic                            sim_clk;
    logic                            reset;
    lvda_pkg::phase_t                phase;
    logic                            pio;
    logic [lvda_pkg::addr_width-1:0] address;
    logic [lvda_pkg::word_width-1:0] data_word;
    logic                            data;
    logic                            data_gate;
    logic                            overrun;
    logic                            rejected;
    logic                            phase_error;

    logic [1:0] phase_idx;
    int         phase_cnt;
    logic       inject_req;
    logic       inject_ack;
    logic       timed_out;
    int         tb_errors;
    int         start_errors;

    initial begin
        sim_clk = 1'b0;
        forever #5 sim_clk = ~sim_clk;
    end

    // Each phase holds 3 cycles, so one bit time is 12 cycles.
    always @(posedge sim_clk) begin
        if (phase_cnt == 2) begin
            phase_cnt <= 0;
            if (inject_req != inject_ack && phase_idx == 2'd0) begin
                phase_idx  <= 2'd2;   // Skips xda.
                inject_ack <= inject_req;
            end else begin
                phase_idx <= phase_idx + 2'd1;
            end
        end else begin
            phase_cnt <= phase_cnt + 1;
        end
    end

    assign phase = lvda_pkg::phase_t'(4'b1000 >> phase_idx);

    lvda u_dut (.*);

    lvda_checker u_checker (.*);

    task automatic wait_for_yda();
        int n;
        n = 0;
        do begin
            @(posedge sim_clk);
            n++;
        end while (!(phase_idx == 2'd2 && phase_cnt == 1) && n < 100);
        if (n >= 100) begin
            $display("Timeout waiting for the yda phase");
            timed_out = 1'b1;
        end
    endtask

    task automatic send_now(input logic [8:0] a, input logic [25:0] d);
        pio       <= 1'b1;
        address   <= a;
        data_word <= d;
        @(posedge sim_clk);
        pio <= 1'b0;
    endtask

    task automatic send_request(input logic [8:0] a, input logic [25:0] d);
        wait_for_yda();
        send_now(a, d);
    endtask

    task automatic wait_until_loaded();
        int n;
        n = 0;
        @(posedge sim_clk);
        while (u_checker.model_pending && n < 1000) begin
            @(posedge sim_clk);
            n++;
        end
        if (n >= 1000) begin
            $display("Timeout waiting for a request to load");
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        repeat (2) @(posedge sim_clk);
        while (u_checker.busy && n < 3000) begin
            @(posedge sim_clk);
            n++;
        end
        if (n >= 3000) begin
            $display("Timeout waiting for the serializer to go idle");
            timed_out = 1'b1;
        end
    endtask

    task automatic check_phase_error(input logic expected);
        if (phase_error !== expected) begin
            $display("ERROR t=%0t phase_error expected %0b got %0b",
                     $time, expected, phase_error);
            tb_errors++;
        end
    endtask

    task automatic report(input string name);
        $display("test %s: %0d errors", name, u_checker.errors + tb_errors - start_errors);
        start_errors = u_checker.errors + tb_errors;
    endtask

    initial begin
        #2_000_000;
        $display("Simulation time limit reached");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        logic [8:0]  a;
        logic [25:0] d;
        int          n;
        void'($urandom(31));
        reset = 1'b1;
        pio = 1'b0;
        address = '0;
        data_word = '0;
        phase_idx = 2'd0;
        phase_cnt = 0;
        inject_req = 1'b0;
        inject_ack = 1'b0;
        timed_out = 1'b0;
        tb_errors = 0;
        start_errors = 0;
        repeat (4) @(posedge sim_clk);
        reset <= 1'b0;

        send_request(9'h1A5, 26'h2B3C4D5);
        wait_idle();
        report("1 full word");

        send_request(9'h0C3, 26'h1F0A5A5);
        wait_idle();
        report("2 half word");

        send_request(9'h02B, 26'h0123456);
        wait_idle();
        report("3 rejected code");

        send_request(9'h155, 26'h3FFFFFF);
        @(posedge sim_clk);
        send_now(9'h0FF, 26'h0000001);
        send_request(9'h1C0, 26'h0AAAAAA);
        wait_idle();
        report("4 overrun");

        // Phases in order so far, so no error may be flagged yet.
        check_phase_error(1'b0);
        inject_req <= 1'b1;
        n = 0;
        while (!phase_error && n < 200) begin
            @(posedge sim_clk);
            n++;
        end
        if (n >= 200) begin
            $display("Timeout waiting for phase_error");
            timed_out = 1'b1;
        end
        repeat (30) @(posedge sim_clk);
        check_phase_error(1'b1);
        reset <= 1'b1;
        repeat (4) @(posedge sim_clk);
        reset <= 1'b0;
        @(posedge sim_clk);
        check_phase_error(1'b0);
        report("5 phase order");

        for (int i = 0; i < 40; i++) begin
            a = 9'($urandom);
            d = 26'($urandom);
            if (a[8:6] == lvda_pkg::code_reject) begin
                a[6] = 1'b1;
            end
            send_request(a, d);
            wait_until_loaded();
        end
        wait_idle();
        check_phase_error(1'b0);   // Relocking after reset must not flag an error.
        report("6 random requests");

        $display("frames %0d, errors %0d, timeouts %0b",
                 u_checker.frames, u_checker.errors + tb_errors, timed_out);
        if (u_checker.errors == 0 && tb_errors == 0 && !timed_out) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- tb.f
lvda_pkg.sv
bit_timing.sv
address_decode.sv
serial_sampler.sv
lvda.sv
lvda_props.sv
lvda_checker.sv
tb_lvda.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_lvda
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -f tb.f -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -qF '*** PASSED ***' $(LOG); then \
		echo "Simulation did not finish"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
